// File: hdl/valu_pkg.sv
`default_nettype none

package valu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int VEC_BITS  = 64;
    localparam int VEC_BYTES = VEC_BITS / 8;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Unlisted codes fall back to add
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_RSUB  = 5'd2,
        OP_AND   = 5'd3,
        OP_OR    = 5'd4,
        OP_XOR   = 5'd5,
        OP_SLL   = 5'd6,
        OP_SRL   = 5'd7,
        OP_SRA   = 5'd8,
        OP_MIN   = 5'd9,
        OP_MINU  = 5'd10,
        OP_MAX   = 5'd11,
        OP_MAXU  = 5'd12,
        OP_MSEQ  = 5'd13,
        OP_MSNE  = 5'd14,
        OP_MSLTU = 5'd15,
        OP_MSLT  = 5'd16,
        OP_MSLEU = 5'd17,
        OP_MSLE  = 5'd18,
        OP_MSGTU = 5'd19,
        OP_MSGT  = 5'd20
    } valu_op_e;

    // Code 2'b11 is treated as 32-bit elements
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } sew_e;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    // One register group word seen as 8, 16 or 32 bit lanes, lane 0 at the LSB
    typedef union packed {
        logic [VEC_BYTES-1:0][7:0]      e8;
        logic [VEC_BITS/16-1:0][15:0]   e16;
        logic [VEC_BITS/32-1:0][31:0]   e32;
    } vec_word_u;

    typedef struct packed {
        logic      valid;
        valu_op_e  op;
        sew_e      sew;
        vec_word_u operand_a;
        vec_word_u operand_b;
    } valu_req_t;

    typedef struct packed {
        logic      valid;
        vec_word_u result;
    } valu_rsp_t;

endpackage

`default_nettype wire

// File: hdl/valu_adder.sv
`timescale 1ns/1ps
`default_nettype none

module valu_adder
    import valu_pkg::*;
(
    input  valu_req_t req_i,
    output vec_word_u sum_o
);

    vec_word_u lhs;
    vec_word_u rhs;
    logic      negate;
    vec_word_u sum_8;
    vec_word_u sum_16;
    vec_word_u sum_32;

    // Operand order per operation
    always_comb begin
        case (req_i.op)
            OP_SUB: begin
                lhs    = req_i.operand_a;
                rhs    = req_i.operand_b;
                negate = 1'b1;
            end
            OP_RSUB: begin
                lhs    = req_i.operand_b;
                rhs    = req_i.operand_a;
                negate = 1'b1;
            end
            default: begin
                lhs    = req_i.operand_a;
                rhs    = req_i.operand_b;
                negate = 1'b0;
            end
        endcase
    end

    // Negation and sum are done lane by lane, so no carry leaves its lane
    always_comb begin
        for (int i = 0; i < VEC_BYTES; i++) begin
            sum_8.e8[i] = lhs.e8[i] + (negate ? ~rhs.e8[i] + 8'd1 : rhs.e8[i]);
        end
        for (int i = 0; i < VEC_BYTES/2; i++) begin
            sum_16.e16[i] = lhs.e16[i] + (negate ? ~rhs.e16[i] + 16'd1 : rhs.e16[i]);
        end
        for (int i = 0; i < VEC_BYTES/4; i++) begin
            sum_32.e32[i] = lhs.e32[i] + (negate ? ~rhs.e32[i] + 32'd1 : rhs.e32[i]);
        end
    end

    always_comb begin
        case (req_i.sew)
            EW8:     sum_o = sum_8;
            EW16:    sum_o = sum_16;
            default: sum_o = sum_32;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/valu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module valu_shifter
    import valu_pkg::*;
(
    input  valu_req_t req_i,
    output vec_word_u shifted_o
);

    vec_word_u op_a;
    vec_word_u op_b;
    vec_word_u shift_8;
    vec_word_u shift_16;
    vec_word_u shift_32;

    assign op_a = req_i.operand_a;
    assign op_b = req_i.operand_b;

    // Shift amount is the low log2(SEW) bits of each operand_b lane
    always_comb begin
        for (int i = 0; i < VEC_BYTES; i++) begin
            case (req_i.op)
                OP_SRL:  shift_8.e8[i] = op_a.e8[i] >> op_b.e8[i][2:0];
                OP_SRA:  shift_8.e8[i] = $signed(op_a.e8[i]) >>> op_b.e8[i][2:0];
                default: shift_8.e8[i] = op_a.e8[i] << op_b.e8[i][2:0];
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < VEC_BYTES/2; i++) begin
            case (req_i.op)
                OP_SRL:  shift_16.e16[i] = op_a.e16[i] >> op_b.e16[i][3:0];
                OP_SRA:  shift_16.e16[i] = $signed(op_a.e16[i]) >>> op_b.e16[i][3:0];
                default: shift_16.e16[i] = op_a.e16[i] << op_b.e16[i][3:0];
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < VEC_BYTES/4; i++) begin
            case (req_i.op)
                OP_SRL:  shift_32.e32[i] = op_a.e32[i] >> op_b.e32[i][4:0];
                OP_SRA:  shift_32.e32[i] = $signed(op_a.e32[i]) >>> op_b.e32[i][4:0];
                default: shift_32.e32[i] = op_a.e32[i] << op_b.e32[i][4:0];
            endcase
        end
    end

    always_comb begin
        case (req_i.sew)
            EW8:     shifted_o = shift_8;
            EW16:    shifted_o = shift_16;
            default: shifted_o = shift_32;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/valu_compare.sv
`timescale 1ns/1ps
`default_nettype none

module valu_compare
    import valu_pkg::*;
(
    input  valu_req_t req_i,
    output vec_word_u minmax_o,
    output vec_word_u mask_o
);

    vec_word_u              op_a;
    vec_word_u              op_b;
    logic [VEC_BYTES-1:0]   eq_8;
    logic [VEC_BYTES-1:0]   gtu_8;
    logic [VEC_BYTES-1:0]   gts_8;
    logic [VEC_BYTES/2-1:0] eq_16;
    logic [VEC_BYTES/2-1:0] gtu_16;
    logic [VEC_BYTES/2-1:0] gts_16;
    logic [VEC_BYTES/4-1:0] eq_32;
    logic [VEC_BYTES/4-1:0] gtu_32;
    logic [VEC_BYTES/4-1:0] gts_32;
    logic [VEC_BYTES-1:0]   eq;
    logic [VEC_BYTES-1:0]   gtu;
    logic [VEC_BYTES-1:0]   gts;
    logic [VEC_BYTES-1:0]   lane_en;
    logic [VEC_BYTES-1:0]   mask_bits;
    logic [VEC_BYTES-1:0]   gt_sel;
    logic [VEC_BYTES-1:0]   take_a;
    logic                   signed_op;
    logic                   max_op;

    assign op_a = req_i.operand_a;
    assign op_b = req_i.operand_b;

    ////////////////////////////////////////////////////////////
    // Lane flags
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < VEC_BYTES; i++) begin
            eq_8[i]  = op_a.e8[i] == op_b.e8[i];
            gtu_8[i] = op_a.e8[i] > op_b.e8[i];
            gts_8[i] = $signed(op_a.e8[i]) > $signed(op_b.e8[i]);
        end
        for (int i = 0; i < VEC_BYTES/2; i++) begin
            eq_16[i]  = op_a.e16[i] == op_b.e16[i];
            gtu_16[i] = op_a.e16[i] > op_b.e16[i];
            gts_16[i] = $signed(op_a.e16[i]) > $signed(op_b.e16[i]);
        end
        for (int i = 0; i < VEC_BYTES/4; i++) begin
            eq_32[i]  = op_a.e32[i] == op_b.e32[i];
            gtu_32[i] = op_a.e32[i] > op_b.e32[i];
            gts_32[i] = $signed(op_a.e32[i]) > $signed(op_b.e32[i]);
        end
    end

    // Flags of the active SEW, packed from lane 0 upwards
    always_comb begin
        case (req_i.sew)
            EW8: begin
                eq      = eq_8;
                gtu     = gtu_8;
                gts     = gts_8;
                lane_en = {VEC_BYTES{1'b1}};
            end
            EW16: begin
                eq      = VEC_BYTES'(eq_16);
                gtu     = VEC_BYTES'(gtu_16);
                gts     = VEC_BYTES'(gts_16);
                lane_en = VEC_BYTES'({(VEC_BYTES/2){1'b1}});
            end
            default: begin
                eq      = VEC_BYTES'(eq_32);
                gtu     = VEC_BYTES'(gtu_32);
                gts     = VEC_BYTES'(gts_32);
                lane_en = VEC_BYTES'({(VEC_BYTES/4){1'b1}});
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Compare mask
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            OP_MSNE:  mask_bits = ~eq;
            OP_MSLTU: mask_bits = ~eq & ~gtu;
            OP_MSLT:  mask_bits = ~eq & ~gts;
            OP_MSLEU: mask_bits = ~gtu;
            OP_MSLE:  mask_bits = ~gts;
            OP_MSGTU: mask_bits = gtu;
            OP_MSGT:  mask_bits = gts;
            default:  mask_bits = eq;
        endcase
    end

    // Bits past the lane count stay zero
    assign mask_o = VEC_BITS'(mask_bits & lane_en);

    ////////////////////////////////////////////////////////////
    // Min and max
    ////////////////////////////////////////////////////////////

    assign signed_op = req_i.op inside {OP_MIN, OP_MAX};
    assign max_op    = req_i.op inside {OP_MAX, OP_MAXU};
    assign gt_sel    = signed_op ? gts : gtu;
    assign take_a    = max_op ? gt_sel : ~gt_sel;

    always_comb begin
        case (req_i.sew)
            EW8: begin
                for (int i = 0; i < VEC_BYTES; i++) begin
                    minmax_o.e8[i] = take_a[i] ? op_a.e8[i] : op_b.e8[i];
                end
            end
            EW16: begin
                for (int i = 0; i < VEC_BYTES/2; i++) begin
                    minmax_o.e16[i] = take_a[i] ? op_a.e16[i] : op_b.e16[i];
                end
            end
            default: begin
                for (int i = 0; i < VEC_BYTES/4; i++) begin
                    minmax_o.e32[i] = take_a[i] ? op_a.e32[i] : op_b.e32[i];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/valu_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module valu_result_stage
    import valu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  valu_req_t req_i,
    input  vec_word_u sum_i,
    input  vec_word_u shifted_i,
    input  vec_word_u minmax_i,
    input  vec_word_u mask_i,
    output valu_rsp_t rsp_o
);

    vec_word_u and_res;
    vec_word_u or_res;
    vec_word_u xor_res;
    valu_rsp_t rsp_d;

    ////////////////////////////////////////////////////////////
    // Logic ops
    ////////////////////////////////////////////////////////////

    // Bitwise, so the lane width plays no part
    assign and_res = req_i.operand_a & req_i.operand_b;
    assign or_res  = req_i.operand_a | req_i.operand_b;
    assign xor_res = req_i.operand_a ^ req_i.operand_b;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        rsp_d.valid = req_i.valid;
        case (req_i.op)
            OP_AND:  rsp_d.result = and_res;
            OP_OR:   rsp_d.result = or_res;
            OP_XOR:  rsp_d.result = xor_res;
            OP_SLL,
            OP_SRL,
            OP_SRA:  rsp_d.result = shifted_i;
            OP_MIN,
            OP_MINU,
            OP_MAX,
            OP_MAXU: rsp_d.result = minmax_i;
            OP_MSEQ,
            OP_MSNE,
            OP_MSLTU,
            OP_MSLT,
            OP_MSLEU,
            OP_MSLE,
            OP_MSGTU,
            OP_MSGT: rsp_d.result = mask_i;
            // Add, sub, rsub and unused codes
            default: rsp_d.result = sum_i;
        endcase
    end

    // Single pipeline register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_o <= '0;
        end else begin
            rsp_o <= rsp_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/valu_top.sv
`timescale 1ns/1ps
`default_nettype none

module valu_top
    import valu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  valu_req_t req_i,
    output valu_rsp_t rsp_o
);

    vec_word_u sum;
    vec_word_u shifted;
    vec_word_u minmax;
    vec_word_u mask;

    // Combinational units, all fed by the same request
    valu_adder u_adder (
        .req_i (req_i),
        .sum_o (sum)
    );

    valu_shifter u_shifter (
        .req_i     (req_i),
        .shifted_o (shifted)
    );

    valu_compare u_compare (
        .req_i    (req_i),
        .minmax_o (minmax),
        .mask_o   (mask)
    );

    // Select and register
    valu_result_stage u_result_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_i     (req_i),
        .sum_i     (sum),
        .shifted_i (shifted),
        .minmax_i  (minmax),
        .mask_i    (mask),
        .rsp_o     (rsp_o)
    );

endmodule

`default_nettype wire

// File: verification/valu_props.sv
`timescale 1ns/1ps
`default_nettype none

module valu_props
    import valu_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input valu_req_t req_i,
    input valu_rsp_t rsp_i
);

    logic       is_cmp;
    logic [6:0] lanes;
    int         n_failures = 0;

    assign is_cmp = req_i.op inside {[OP_MSEQ:OP_MSGT]};
    assign lanes  = (req_i.sew == EW8) ? 7'd8 : (req_i.sew == EW16) ? 7'd4 : 7'd2;

    valid_in_reset: assert property (@(posedge clk) !reset_n |-> !rsp_i.valid)
        else begin
            n_failures++;
            $error("rsp_o.valid high while reset is asserted");
        end

    // One cycle latency in both directions
    valid_follows_req: assert property (@(posedge clk) disable iff (!reset_n)
        1'b1 |=> (rsp_i.valid == $past(req_i.valid)))
        else begin
            n_failures++;
            $error("rsp_o.valid does not follow req_i.valid by one cycle");
        end

    // A compare response carries one bit per lane and nothing above
    mask_upper_zero: assert property (@(posedge clk) disable iff (!reset_n)
        (req_i.valid && is_cmp) |=> ((64'(rsp_i.result) >> $past(lanes)) == '0))
        else begin
            n_failures++;
            $error("compare result has bits set above the lane count");
        end

endmodule

bind valu_top valu_props u_props (
    .clk     (clk),
    .reset_n (reset_n),
    .req_i   (req_i),
    .rsp_i   (rsp_o)
);

`default_nettype wire

// File: verification/valu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module valu_tb
    import valu_pkg::*;
();

    localparam int DRAIN_CYCLES = 20;

    logic        clk;
    logic        reset_n;
    valu_req_t   req;
    valu_rsp_t   rsp;
    integer      seed;
    int          cycle;
    int          n_checks;
    int          n_errors;
    int          error_mark;
    logic        skip_checks;
    logic [63:0] exp_q[$];
    string       name_q[$];
    int          cyc_q[$];

    valu_top uut (.clk(clk), .reset_n(reset_n), .req_i(req), .rsp_o(rsp));

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [63:0] valu_ref(input valu_op_e op, input sew_e sew,
                                             input logic [63:0] a, input logic [63:0] b);
        int          w;
        logic [31:0] lmask;
        logic [31:0] sign;
        logic [31:0] la;
        logic [31:0] lb;
        logic [31:0] sh;
        logic [31:0] r;
        logic        eq;
        logic        lt_u;
        logic        lt_s;
        logic [63:0] res;
        w     = (sew == EW8) ? 8 : (sew == EW16) ? 16 : 32;
        lmask = 32'hffff_ffff >> (32 - w);
        sign  = 32'd1 << (w - 1);
        res   = '0;
        for (int i = 0; i < 64 / w; i++) begin
            la   = 32'(a >> (i * w)) & lmask;
            lb   = 32'(b >> (i * w)) & lmask;
            sh   = lb % w;
            eq   = la == lb;
            lt_u = la < lb;
            // Flipped sign bits turn signed order into unsigned order
            lt_s = (la ^ sign) < (lb ^ sign);
            case (op)
                OP_SUB:   r = la - lb;
                OP_RSUB:  r = lb - la;
                OP_AND:   r = la & lb;
                OP_OR:    r = la | lb;
                OP_XOR:   r = la ^ lb;
                OP_SLL:   r = la << sh;
                OP_SRL:   r = la >> sh;
                OP_SRA:   r = (la >> sh) | ((la & sign) ? lmask & ~(lmask >> sh) : 32'd0);
                OP_MIN:   r = lt_s ? la : lb;
                OP_MINU:  r = lt_u ? la : lb;
                OP_MAX:   r = lt_s ? lb : la;
                OP_MAXU:  r = lt_u ? lb : la;
                OP_MSEQ:  r = 32'(eq);
                OP_MSNE:  r = 32'(!eq);
                OP_MSLTU: r = 32'(lt_u);
                OP_MSLT:  r = 32'(lt_s);
                OP_MSLEU: r = 32'(lt_u || eq);
                OP_MSLE:  r = 32'(lt_s || eq);
                OP_MSGTU: r = 32'(!(lt_u || eq));
                OP_MSGT:  r = 32'(!(lt_s || eq));
                default:  r = la + lb;
            endcase
            // Compares give one mask bit per lane
            if (op >= OP_MSEQ && op <= OP_MSGT) res[i] = r[0];
            else res = res | (64'(r & lmask) << (i * w));
        end
        return res;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // Value 1 in every lane
    function automatic logic [63:0] lane_ones(input sew_e sew);
        case (sew)
            EW8:     return 64'h0101_0101_0101_0101;
            EW16:    return 64'h0001_0001_0001_0001;
            default: return 64'h0000_0001_0000_0001;
        endcase
    endfunction

    task automatic send(input valu_op_e op, input sew_e sew, input logic [63:0] a,
                        input logic [63:0] b, input string name);
        @(negedge clk);
        req.valid     = 1'b1;
        req.op        = op;
        req.sew       = sew;
        req.operand_a = a;
        req.operand_b = b;
        exp_q.push_back(valu_ref(op, sew, a, b));
        name_q.push_back(name);
        cyc_q.push_back(cycle);
    endtask

    task automatic idle();
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    // Let the pipeline empty, then report the test
    task automatic end_test(input string name);
        int waited;
        idle();
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Error: no response arrived for %0d requests of test %s",
                     exp_q.size(), name);
            n_errors += exp_q.size();
            exp_q.delete();
            name_q.delete();
            cyc_q.delete();
        end
        $display("Test %s finished with %0d errors", name, n_errors - error_mark);
        error_mark = n_errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Response check
    ////////////////////////////////////////////////////////////

    // Sampled half a cycle after the edge that loaded rsp_o
    always @(negedge clk) begin
        logic [63:0] exp;
        string       name;
        int          req_cyc;
        if (reset_n && !skip_checks && rsp.valid) begin
            if (exp_q.size() == 0) begin
                $display("Error: response valid with no request pending");
                n_errors++;
            end else begin
                exp     = exp_q.pop_front();
                name    = name_q.pop_front();
                req_cyc = cyc_q.pop_front();
                n_checks++;
                assert (cycle == req_cyc + 1) else begin
                    $display("Error: %s answered %0d cycles after its request",
                             name, cycle - req_cyc);
                    n_errors++;
                end
                assert (rsp.result === exp) else begin
                    $display("Mismatch %s: expected %h, actual %h", name, exp, rsp.result);
                    n_errors++;
                end
            end
        end
    end

    initial begin
        logic [63:0] r;
        logic [63:0] sb;
        logic [31:0] pick;
        string       tname;
        seed        = 49;
        clk         = 1'b0;
        reset_n     = 1'b1;
        req         = '0;
        cycle       = 0;
        n_checks    = 0;
        n_errors    = 0;
        error_mark  = 0;
        skip_checks = 1'b0;
        // Reset falls after time zero so the result register sees the edge
        #1;
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Per-lane wrap and borrow
        for (int s = 0; s < 3; s++) begin
            for (int o = OP_ADD; o <= OP_RSUB; o++) begin
                tname = $sformatf("arith op%0d e%0d", o, 8 << s);
                send(valu_op_e'(o), sew_e'(s), '1, lane_ones(sew_e'(s)), tname);
                send(valu_op_e'(o), sew_e'(s), '0, lane_ones(sew_e'(s)), tname);
                send(valu_op_e'(o), sew_e'(s), rand64(), rand64(), tname);
            end
        end
        end_test("arith");

        for (int i = 0; i < 12; i++) begin
            pick = $random(seed);
            send(valu_op_e'(OP_AND + i % 3), sew_e'(pick[1:0]), rand64(), rand64(),
                 $sformatf("logic #%0d", i));
        end
        end_test("logic");

        // Negative lanes and amounts with bits above the shift range
        for (int s = 0; s < 3; s++) begin
            for (int o = OP_SLL; o <= OP_SRA; o++) begin
                tname = $sformatf("shift op%0d e%0d", o, 8 << s);
                send(valu_op_e'(o), sew_e'(s), 64'h8F00_F0FF_A5C3_E001,
                     rand64() | 64'hE0E0_E0E0_E0E0_E0E0, tname);
                send(valu_op_e'(o), sew_e'(s), rand64(), rand64(), tname);
            end
        end
        end_test("shift");

        for (int s = 0; s < 3; s++) begin
            sb = lane_ones(sew_e'(s)) << ((8 << s) - 1);
            for (int o = OP_MIN; o <= OP_MSGT; o++) begin
                tname = $sformatf("compare op%0d e%0d", o, 8 << s);
                r     = rand64();
                send(valu_op_e'(o), sew_e'(s), r, r, tname);
                send(valu_op_e'(o), sew_e'(s), r, r ^ sb, tname);
                send(valu_op_e'(o), sew_e'(s), ~sb, sb, tname);
                send(valu_op_e'(o), sew_e'(s), '0, '1, tname);
                send(valu_op_e'(o), sew_e'(s), rand64(), rand64(), tname);
            end
        end
        end_test("compare");

        // Undefined op and SEW codes are part of the stream
        for (int i = 0; i < 200; i++) begin
            pick = $random(seed);
            if (pick[9:8] == 2'b00) idle();
            send(valu_op_e'(pick[4:0]), sew_e'(pick[6:5]), rand64(), rand64(),
                 $sformatf("stream #%0d", i));
        end
        end_test("stream");

        // Reset with one request in flight
        @(negedge clk);
        skip_checks = 1'b1;
        req.valid   = 1'b1;
        @(negedge clk);
        reset_n   = 1'b0;
        req.valid = 1'b0;
        #1;
        n_checks++;
        assert (!rsp.valid) else begin
            $display("Error: rsp_o.valid did not drop when reset was asserted");
            n_errors++;
        end
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (i == 3) reset_n = 1'b1;
            n_checks++;
            assert (!rsp.valid) else begin
                $display("Error: rsp_o.valid went high around reset with no request");
                n_errors++;
            end
        end
        skip_checks = 1'b0;
        for (int i = 0; i < 20; i++) begin
            pick = $random(seed);
            send(valu_op_e'(pick[4:0]), sew_e'(pick[6:5]), rand64(), rand64(),
                 $sformatf("after reset #%0d", i));
        end
        end_test("reset");

        // Failures of the bound concurrent assertions
        n_errors += uut.u_props.n_failures;

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/valu_pkg.sv
hdl/valu_adder.sv
hdl/valu_shifter.sv
hdl/valu_compare.sv
hdl/valu_result_stage.sv
hdl/valu_top.sv
verification/valu_props.sv
verification/valu_tb.sv

// File: Bender.yml
package:
  name: valu

sources:
  - hdl/valu_pkg.sv
  - hdl/valu_adder.sv
  - hdl/valu_shifter.sv
  - hdl/valu_compare.sv
  - hdl/valu_result_stage.sv
  - hdl/valu_top.sv
  - target: test
    files:
      - verification/valu_props.sv
      - verification/valu_tb.sv
